//--- exu_cfg_pkg.sv
package exu_cfg_pkg;

    // Data word width
    localparam int xlen = 64;

    // ROB tag including the wrap bit
    localparam int rob_id_width = 6;

    // Physical register index
    localparam int preg_width = 6;

    // Full-width shift amount, word mode uses one bit less
    localparam int shamt_width = 6;

endpackage

//--- exu_types_pkg.sv
package exu_types_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu
    } alu_op_e;

    // One integer issue from dispatch
    typedef struct packed {
        logic [exu_cfg_pkg::rob_id_width-1:0] robid;
        logic [exu_cfg_pkg::preg_width-1:0]   prd;
        logic                                 need_to_wb;
        alu_op_e                              alu_op;
        logic [exu_cfg_pkg::xlen-1:0]         src1;
        logic [exu_cfg_pkg::xlen-1:0]         src2;
        logic [exu_cfg_pkg::xlen-1:0]         imm;
        logic                                 is_imm;
        logic                                 is_word;
    } issue_t;

    // One writeback record
    typedef struct packed {
        logic [exu_cfg_pkg::rob_id_width-1:0] robid;
        logic [exu_cfg_pkg::preg_width-1:0]   prd;
        logic                                 need_to_wb;
        logic [exu_cfg_pkg::xlen-1:0]         result;
    } wb_rec_t;

    typedef enum logic {
        iss_idle,
        iss_ack
    } issue_state_e;

    typedef enum logic [1:0] {
        wb_idle,
        wb_req_high,
        wb_wait_low
    } wb_state_e;

endpackage

//--- int_alu.sv
`timescale 1ns/100ps

module int_alu (
    input  logic                   clock,
    input  logic                   arst_n,

    input  logic                   issue_req,
    input  exu_types_pkg::issue_t  issue,
    output logic                   issue_ack,

    input  logic                   full,
    output logic                   push,
    output exu_types_pkg::wb_rec_t push_rec
);

    logic [exu_cfg_pkg::xlen-1:0]        op2;
    logic [exu_cfg_pkg::shamt_width-1:0] shamt;
    logic [31:0]                         src1_w;
    logic [31:0]                         op2_w;
    logic [31:0]                         res_w;
    logic [exu_cfg_pkg::xlen-1:0]        res_d;
    logic [exu_cfg_pkg::xlen-1:0]        result;
    exu_types_pkg::issue_state_e         state;

    assign op2    = issue.is_imm ? issue.imm : issue.src2;
    assign src1_w = issue.src1[31:0];
    assign op2_w  = op2[31:0];

    // Word shifts only look at five bits
    assign shamt = issue.is_word ? {1'b0, op2[exu_cfg_pkg::shamt_width-2:0]}
                                 : op2[exu_cfg_pkg::shamt_width-1:0];

    // Full-width result
    always_comb begin
        case (issue.alu_op)
            exu_types_pkg::op_add:  res_d = issue.src1 + op2;
            exu_types_pkg::op_sub:  res_d = issue.src1 - op2;
            exu_types_pkg::op_and:  res_d = issue.src1 & op2;
            exu_types_pkg::op_or:   res_d = issue.src1 | op2;
            exu_types_pkg::op_xor:  res_d = issue.src1 ^ op2;
            exu_types_pkg::op_sll:  res_d = issue.src1 << shamt;
            exu_types_pkg::op_srl:  res_d = issue.src1 >> shamt;
            exu_types_pkg::op_sra:  res_d = $unsigned($signed(issue.src1) >>> shamt);
            exu_types_pkg::op_slt: begin
                res_d = '0;
                res_d[0] = $signed(issue.src1) < $signed(op2);
            end
            exu_types_pkg::op_sltu: begin
                res_d = '0;
                res_d[0] = issue.src1 < op2;
            end
            default: res_d = '0;
        endcase
    end

    // Word result on the low halves
    always_comb begin
        case (issue.alu_op)
            exu_types_pkg::op_add:  res_w = src1_w + op2_w;
            exu_types_pkg::op_sub:  res_w = src1_w - op2_w;
            exu_types_pkg::op_and:  res_w = src1_w & op2_w;
            exu_types_pkg::op_or:   res_w = src1_w | op2_w;
            exu_types_pkg::op_xor:  res_w = src1_w ^ op2_w;
            exu_types_pkg::op_sll:  res_w = src1_w << shamt[4:0];
            exu_types_pkg::op_srl:  res_w = src1_w >> shamt[4:0];
            exu_types_pkg::op_sra:  res_w = $unsigned($signed(src1_w) >>> shamt[4:0]);
            exu_types_pkg::op_slt: begin
                res_w = '0;
                res_w[0] = $signed(src1_w) < $signed(op2_w);
            end
            exu_types_pkg::op_sltu: begin
                res_w = '0;
                res_w[0] = src1_w < op2_w;
            end
            default: res_w = '0;
        endcase
    end

    assign result = issue.is_word ? {{(exu_cfg_pkg::xlen-32){res_w[31]}}, res_w} : res_d;

    // Issue side of the four-phase exchange
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= exu_types_pkg::iss_idle;
        end else begin
            case (state)
                exu_types_pkg::iss_idle: begin
                    if (issue_req && !full) begin
                        state <= exu_types_pkg::iss_ack;
                    end
                end
                exu_types_pkg::iss_ack: begin
                    if (!issue_req) begin
                        state <= exu_types_pkg::iss_idle;
                    end
                end
                default: state <= exu_types_pkg::iss_idle;
            endcase
        end
    end

    assign issue_ack = (state == exu_types_pkg::iss_ack);

    // Result enters the queue on the edge that raises ack
    assign push = (state == exu_types_pkg::iss_idle) && issue_req && !full;

    always_comb begin
        push_rec.robid      = issue.robid;
        push_rec.prd        = issue.prd;
        push_rec.need_to_wb = issue.need_to_wb;
        push_rec.result     = result;
    end

endmodule

//--- wb_queue.sv
`timescale 1ns/100ps

module wb_queue #(
    parameter int wb_depth = 4
) (
    input  logic                   clock,
    input  logic                   arst_n,

    input  logic                   push,
    input  exu_types_pkg::wb_rec_t push_rec,

    input  logic                   pop,
    output exu_types_pkg::wb_rec_t head,

    output logic                   full,
    output logic                   empty
);

    localparam int ptr_w = $clog2(wb_depth);
    localparam int cnt_w = $clog2(wb_depth + 1);
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(wb_depth - 1);

    exu_types_pkg::wb_rec_t mem [wb_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    // Pointers wrap at the last slot, depth need not be a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest record
    assign head  = mem[rd_ptr];
    assign full  = (count == cnt_w'(wb_depth));
    assign empty = (count == '0);

endmodule

//--- wb_port.sv
`timescale 1ns/100ps

module wb_port (
    input  logic                   clock,
    input  logic                   arst_n,

    input  logic                   empty,
    input  exu_types_pkg::wb_rec_t head,
    output logic                   pop,

    output logic                   wb_req,
    output exu_types_pkg::wb_rec_t wb,
    input  logic                   wb_ack
);

    exu_types_pkg::wb_state_e state;

    assign pop    = (state == exu_types_pkg::wb_idle) && !empty;
    assign wb_req = (state == exu_types_pkg::wb_req_high);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= exu_types_pkg::wb_idle;
        end else begin
            case (state)
                exu_types_pkg::wb_idle: begin
                    if (!empty) begin
                        state <= exu_types_pkg::wb_req_high;
                    end
                end
                exu_types_pkg::wb_req_high: begin
                    if (wb_ack) begin
                        state <= exu_types_pkg::wb_wait_low;
                    end
                end
                // Receiver must release ack before the next request
                exu_types_pkg::wb_wait_low: begin
                    if (!wb_ack) begin
                        state <= exu_types_pkg::wb_idle;
                    end
                end
                default: state <= exu_types_pkg::wb_idle;
            endcase
        end
    end

    // Output record only loads on a pop, stays put for the whole exchange
    always_ff @(posedge clock) begin
        if (pop) begin
            wb <= head;
        end
    end

endmodule

//--- exu_top.sv
`timescale 1ns/100ps

module exu_top #(
    parameter int wb_depth = 4
) (
    input  logic                   clock,
    input  logic                   arst_n,

    input  logic                   issue_req,
    input  exu_types_pkg::issue_t  issue,
    output logic                   issue_ack,

    output logic                   wb_req,
    output exu_types_pkg::wb_rec_t wb,
    input  logic                   wb_ack
);

    logic                   push;
    exu_types_pkg::wb_rec_t push_rec;
    logic                   full;
    logic                   pop;
    exu_types_pkg::wb_rec_t head;
    logic                   empty;

    int_alu u_int_alu (
        .clock    (clock),
        .arst_n   (arst_n),
        .issue_req(issue_req),
        .issue    (issue),
        .issue_ack(issue_ack),
        .full     (full),
        .push     (push),
        .push_rec (push_rec)
    );

    wb_queue #(
        .wb_depth(wb_depth)
    ) u_wb_queue (
        .clock   (clock),
        .arst_n  (arst_n),
        .push    (push),
        .push_rec(push_rec),
        .pop     (pop),
        .head    (head),
        .full    (full),
        .empty   (empty)
    );

    wb_port u_wb_port (
        .clock (clock),
        .arst_n(arst_n),
        .empty (empty),
        .head  (head),
        .pop   (pop),
        .wb_req(wb_req),
        .wb    (wb),
        .wb_ack(wb_ack)
    );

endmodule

//--- exu_top_assert.sv
`timescale 1ns/100ps

module exu_top_assert (
    input logic                   clock,
    input logic                   arst_n,
    input logic                   issue_req,
    input logic                   issue_ack,
    input logic                   wb_req,
    input exu_types_pkg::wb_rec_t wb,
    input logic                   wb_ack
);

    int unsigned fail_count = 0;

    // Record must hold until the receiver answers
    wb_stable: assert property (@(posedge clock) disable iff (!arst_n)
        wb_req && !wb_ack |=> $stable(wb))
    else begin
        fail_count++;
        $error("wb changed while wb_req waited for wb_ack");
    end

    wb_req_rise: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(wb_req) |-> !$past(wb_ack))
    else begin
        fail_count++;
        $error("wb_req rose while wb_ack was still high");
    end

    issue_ack_rise: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(issue_ack) |-> $past(issue_req))
    else begin
        fail_count++;
        $error("issue_ack rose without issue_req");
    end

    // Both sides quiet in reset
    reset_quiet: assert property (@(posedge clock)
        !arst_n |-> !issue_ack && !wb_req)
    else begin
        fail_count++;
        $error("issue_ack or wb_req high during reset");
    end

endmodule

bind exu_top exu_top_assert u_exu_top_assert (
    .clock    (clock),
    .arst_n   (arst_n),
    .issue_req(issue_req),
    .issue_ack(issue_ack),
    .wb_req   (wb_req),
    .wb       (wb),
    .wb_ack   (wb_ack)
);

//--- tb_exu_top.sv
`timescale 1ns/100ps

module tb_exu_top;

    localparam int wb_depth = 4;
    localparam logic [63:0] edge_vals [6] = '{64'd0, {64{1'b1}}, 64'h8000_0000_0000_0000,
                                              64'h0000_0000_8000_0000, 64'd31, 64'd63};

    logic                   clock;
    logic                   arst_n;
    logic                   issue_req;
    exu_types_pkg::issue_t  issue;
    logic                   issue_ack;
    logic                   wb_req;
    exu_types_pkg::wb_rec_t wb;
    logic                   wb_ack;
    logic                   stall;
    logic                   wb_req_q;

    exu_types_pkg::wb_rec_t exp_q [$];
    int errors   = 0;
    int timeouts = 0;
    int issued   = 0;
    int received = 0;

    exu_top #(.wb_depth(wb_depth)) uut (
        .clock    (clock),
        .arst_n   (arst_n),
        .issue_req(issue_req),
        .issue    (issue),
        .issue_ack(issue_ack),
        .wb_req   (wb_req),
        .wb       (wb),
        .wb_ack   (wb_ack)
    );

    always #2 clock = ~clock;

    task automatic report_and_finish();
        $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, uut.u_exu_top_assert.fail_count);
        if (errors == 0 && timeouts == 0 && uut.u_exu_top_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
        report_and_finish();
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // Expected record from the ALU rules
    function automatic exu_types_pkg::wb_rec_t expected_rec(input exu_types_pkg::issue_t iss);
        logic [63:0]            a;
        logic [63:0]            b;
        logic [63:0]            r;
        logic [5:0]             sh;
        exu_types_pkg::wb_rec_t rec;
        a  = iss.src1;
        b  = iss.is_imm ? iss.imm : iss.src2;
        sh = b[5:0];
        // Word ops work on sign-extended low halves
        if (iss.is_word) begin
            a     = sext32(iss.src1[31:0]);
            b     = sext32(b[31:0]);
            sh[5] = 1'b0;
        end
        case (iss.alu_op)
            exu_types_pkg::op_add:  r = a + b;
            exu_types_pkg::op_sub:  r = a - b;
            exu_types_pkg::op_and:  r = a & b;
            exu_types_pkg::op_or:   r = a | b;
            exu_types_pkg::op_xor:  r = a ^ b;
            exu_types_pkg::op_sll:  r = a << sh;
            exu_types_pkg::op_srl:  r = (iss.is_word ? {32'b0, a[31:0]} : a) >> sh;
            exu_types_pkg::op_sra:  r = $signed(a) >>> sh;
            exu_types_pkg::op_slt:  r = {63'b0, $signed(a) < $signed(b)};
            exu_types_pkg::op_sltu: r = {63'b0, a < b};
            default:                r = '0;
        endcase
        if (iss.is_word) begin
            r = sext32(r[31:0]);
        end
        rec.robid      = iss.robid;
        rec.prd        = iss.prd;
        rec.need_to_wb = iss.need_to_wb;
        rec.result     = r;
        return rec;
    endfunction

    function automatic logic [63:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return edge_vals[0];
            1:       return edge_vals[1];
            2:       return edge_vals[2];
            3:       return edge_vals[3];
            4:       return edge_vals[4];
            5:       return edge_vals[5];
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    function automatic exu_types_pkg::issue_t random_issue();
        exu_types_pkg::issue_t iss;
        iss.robid      = 6'($urandom_range(0, 63));
        iss.prd        = 6'($urandom_range(0, 63));
        iss.need_to_wb = 1'($urandom_range(0, 1));
        iss.alu_op     = exu_types_pkg::alu_op_e'(4'($urandom_range(0, 9)));
        iss.src1       = pick_operand();
        iss.src2       = pick_operand();
        iss.imm        = pick_operand();
        iss.is_imm     = 1'($urandom_range(0, 1));
        iss.is_word    = 1'($urandom_range(0, 1));
        return iss;
    endfunction

    // Four-phase issue with an optional number of cycles that must pass without ack
    task automatic send_issue(input exu_types_pkg::issue_t iss, input int blocked_cycles);
        int cycles;
        @(posedge clock);
        issue     <= iss;
        issue_req <= 1'b1;
        repeat (blocked_cycles) begin
            @(posedge clock);
            check_value("issue_ack with queue full", issue_ack, 0);
        end
        if (blocked_cycles > 0) begin
            stall <= 1'b0;
        end
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 200) timed_out("issue_ack never rose");
        end while (!issue_ack);
        exp_q.push_back(expected_rec(iss));
        issued++;
        issue_req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 20) timed_out("issue_ack never fell");
        end while (issue_ack);
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            if (cycles > 2000) timed_out("wb_req stopped with records still pending");
        end while (exp_q.size() != 0 || wb_req || wb_ack);
    endtask

    initial begin : stimulus
        exu_types_pkg::issue_t iss;
        void'($urandom(32'h07f63377));
        clock     = 1'b0;
        arst_n    = 1'b0;
        issue_req = 1'b0;
        issue     = '0;
        wb_ack    = 1'b0;
        stall     = 1'b0;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        repeat (20) begin
            @(posedge clock);
            check_value("issue_ack after reset", issue_ack, 0);
            check_value("wb_req while idle", wb_req, 0);
        end
        // Edge operands over every opcode, register/immediate and word/full forms
        for (int op = 0; op < 10; op++) begin
            for (int form = 0; form < 4; form++) begin
                for (int i = 0; i < 6; i++) begin
                    for (int j = 0; j < 6; j++) begin
                        iss         = random_issue();
                        iss.alu_op  = exu_types_pkg::alu_op_e'(4'(op));
                        iss.is_imm  = form[0];
                        iss.is_word = form[1];
                        iss.src1    = edge_vals[i];
                        if (iss.is_imm) iss.imm = edge_vals[j];
                        else iss.src2 = edge_vals[j];
                        send_issue(iss, 0);
                    end
                end
            end
        end
        repeat (300) begin
            iss = random_issue();
            repeat ($urandom_range(0, 3)) @(posedge clock);
            send_issue(iss, 0);
        end
        // Port holds one record and the queue fills before the next issue waits
        drain();
        stall <= 1'b1;
        repeat (wb_depth + 1) send_issue(random_issue(), 0);
        send_issue(random_issue(), 40);
        drain();
        check_value("records received", received, issued);
        report_and_finish();
    end

    initial begin : receiver
        int cycles;
        int delay;
        forever begin
            cycles = 0;
            do begin
                @(posedge clock);
                cycles++;
                if (cycles > 1000) timed_out("wb_req never rose");
            end while (!wb_req);
            delay = ($urandom_range(0, 31) == 0) ? 40 : $urandom_range(0, 6);
            repeat (delay) @(posedge clock);
            cycles = 0;
            while (stall) begin
                @(posedge clock);
                cycles++;
                if (cycles > 500) timed_out("receiver stall never released");
            end
            wb_ack <= 1'b1;
            cycles = 0;
            do begin
                @(posedge clock);
                cycles++;
                if (cycles > 20) timed_out("wb_req never fell");
            end while (wb_req);
            wb_ack <= 1'b0;
        end
    end

    // Each wb_req rise carries the oldest expected record
    always @(posedge clock) begin : compare
        exu_types_pkg::wb_rec_t want;
        if (!arst_n) begin
            wb_req_q <= 1'b0;
        end else begin
            if (wb_req && !wb_req_q) begin
                received++;
                check_value("expected record pending", exp_q.size() > 0, 1);
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    check_value("wb.robid", wb.robid, want.robid);
                    check_value("wb.prd", wb.prd, want.prd);
                    check_value("wb.need_to_wb", wb.need_to_wb, want.need_to_wb);
                    check_value("wb.result", wb.result, want.result);
                end
            end
            wb_req_q <= wb_req;
        end
    end

endmodule

//--- flist.f
exu_cfg_pkg.sv
exu_types_pkg.sv
int_alu.sv
wb_queue.sv
wb_port.sv
exu_top.sv
exu_top_assert.sv
tb_exu_top.sv

//--- Bender.yml
package:
  name: exu_wb

sources:
  - exu_cfg_pkg.sv
  - exu_types_pkg.sv
  - int_alu.sv
  - wb_queue.sv
  - wb_port.sv
  - exu_top.sv
  - target: simulation
    files:
      - exu_top_assert.sv
      - tb_exu_top.sv
